//--- hw/rvIsaPkg.sv
/* RV32I instruction set encodings for the kept subset.
   Major opcodes, funct fields and immediate formats shared by decode and tests */
package rvIsaPkg;

    // Major opcodes in bits [6:0]
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeT;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immJ
    } immFmtT;

    localparam logic [2:0] f3AddSub = 3'b000;  // add, sub, addi
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Lw     = 3'b010;
    localparam logic [2:0] f3Sw     = 3'b010;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Jalr   = 3'b000;

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Sub  = 7'b0100000;

endpackage

//--- hw/corePkg.sv
/* Internal control encodings passed between the pipeline blocks */
package corePkg;

    localparam int xlen = 32;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    // Writeback result selection
    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2
    } resultSrcT;

    // Execute operand source
    typedef enum logic [1:0] {
        fwdNone = 2'd0,  // Register file value
        fwdWb   = 2'd1,
        fwdMem  = 2'd2
    } fwdSelT;

endpackage

//--- hw/coreIfs.sv
/* Buses inside the core. ctrlIf joins controller and datapath,
   hazardIf carries register numbers and hazard controls */
`timescale 1ns/1ps

interface ctrlIf;
    logic [corePkg::xlen-1:0] instrD;
    logic                     zeroE;
    rvIsaPkg::immFmtT         immSrcD;
    corePkg::aluOpT           aluControlE;
    logic                     aluSrcE;
    logic                     pcSrcE;      // Branch taken or jump
    logic                     jalrE;       // Target from ALU
    logic                     memWriteM;
    corePkg::resultSrcT       resultSrcW;
    logic                     regWriteW;

    modport controller (input instrD, zeroE,
                        output immSrcD, aluControlE, aluSrcE, pcSrcE, jalrE,
                               memWriteM, resultSrcW, regWriteW);
    modport datapath (output instrD, zeroE,
                      input immSrcD, aluControlE, aluSrcE, pcSrcE, jalrE,
                            memWriteM, resultSrcW, regWriteW);
endinterface

interface hazardIf;
    logic [4:0]      rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
    logic            resultSrcE0;  // Load in Execute
    logic            pcSrcE;
    logic            regWriteM, regWriteW;
    logic            stallF, stallD, flushD, flushE;
    corePkg::fwdSelT forwardAE, forwardBE;

    modport datapath (output rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
                      input stallF, stallD, flushD, flushE, forwardAE, forwardBE);
    modport controller (output resultSrcE0, pcSrcE, regWriteM, regWriteW,
                        input stallD, flushD, flushE);
    modport hazard (input rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
                          resultSrcE0, pcSrcE, regWriteM, regWriteW,
                    output stallF, stallD, flushD, flushE, forwardAE, forwardBE);
endinterface

//--- hw/regFile.sv
/* Integer register file, two read ports and one write port.
   x0 reads as zero and a same-cycle write passes through to the reads */
`timescale 1ns/1ps

module regFile (
    input  logic                     clk,
    input  logic [4:0]               readAddr1,
    input  logic [4:0]               readAddr2,
    output logic [corePkg::xlen-1:0] readData1,
    output logic [corePkg::xlen-1:0] readData2,
    input  logic                     writeEn,
    input  logic [4:0]               writeAddr,
    input  logic [corePkg::xlen-1:0] writeData
);

    logic [corePkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (writeEn && writeAddr != 5'd0) regs[writeAddr] <= writeData;
    end

    assign readData1 = (readAddr1 == 5'd0) ? '0 :
                       (writeEn && readAddr1 == writeAddr) ? writeData : regs[readAddr1];
    assign readData2 = (readAddr2 == 5'd0) ? '0 :
                       (writeEn && readAddr2 == writeAddr) ? writeData : regs[readAddr2];

endmodule

//--- hw/alu.sv
/* Integer ALU for the Execute stage, with zero flag for beq */
`timescale 1ns/1ps

module alu (
    input  logic [corePkg::xlen-1:0] srcA,
    input  logic [corePkg::xlen-1:0] srcB,
    input  corePkg::aluOpT           aluOp,
    output logic [corePkg::xlen-1:0] result,
    output logic                     zero
);

    logic lessThan;

    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (aluOp)
            corePkg::aluAdd: result = srcA + srcB;
            corePkg::aluSub: result = srcA - srcB;
            corePkg::aluAnd: result = srcA & srcB;
            corePkg::aluOr:  result = srcA | srcB;
            corePkg::aluSlt: result = {{(corePkg::xlen-1){1'b0}}, lessThan};
            default:         result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- hw/controller.sv
/* Main decoder for the Decode stage; the control word then rides
   along the pipeline through Execute, Memory and Writeback */
`timescale 1ns/1ps

module controller (
    input logic clk,
    input logic rstN,
    ctrlIf.controller ctrl,
    hazardIf.controller haz
);

    typedef struct packed {
        logic               regWrite;
        corePkg::resultSrcT resultSrc;
        logic               memWrite;
        logic               branch;
        logic               jump;
        logic               jalr;
        corePkg::aluOpT     aluControl;
        logic               aluSrc;
    } ctrlT;

    ctrlT               ctrlD, ctrlE;
    logic               regWriteM, memWriteM, regWriteW, pcSrcE;
    corePkg::resultSrcT resultSrcM, resultSrcW;
    logic [6:0]         opcode, funct7;
    logic [2:0]         funct3;

    assign opcode = ctrl.instrD[6:0];
    assign funct3 = ctrl.instrD[14:12];
    assign funct7 = ctrl.instrD[31:25];

    // ========================================
    // Decode
    always_comb begin
        ctrlD = '0;  // Bubble unless recognised
        ctrl.immSrcD = rvIsaPkg::immI;
        case (opcode)
            rvIsaPkg::opReg: begin
                ctrlD.regWrite = 1'b1;
                case (funct3)
                    rvIsaPkg::f3AddSub:
                        ctrlD.aluControl = (funct7 == rvIsaPkg::f7Sub) ? corePkg::aluSub
                                                                       : corePkg::aluAdd;
                    rvIsaPkg::f3Slt: ctrlD.aluControl = corePkg::aluSlt;
                    rvIsaPkg::f3Or:  ctrlD.aluControl = corePkg::aluOr;
                    rvIsaPkg::f3And: ctrlD.aluControl = corePkg::aluAnd;
                    default:         ctrlD.regWrite = 1'b0;
                endcase
            end
            rvIsaPkg::opImm: begin
                ctrlD.regWrite = (funct3 == rvIsaPkg::f3AddSub);  // addi only
                ctrlD.aluSrc   = 1'b1;
            end
            rvIsaPkg::opLoad: begin
                ctrlD.regWrite  = (funct3 == rvIsaPkg::f3Lw);
                ctrlD.resultSrc = corePkg::resMem;
                ctrlD.aluSrc    = 1'b1;
            end
            rvIsaPkg::opStore: begin
                ctrl.immSrcD   = rvIsaPkg::immS;
                ctrlD.memWrite = (funct3 == rvIsaPkg::f3Sw);
                ctrlD.aluSrc   = 1'b1;
            end
            rvIsaPkg::opBranch: begin
                ctrl.immSrcD     = rvIsaPkg::immB;
                ctrlD.branch     = (funct3 == rvIsaPkg::f3Beq);
                ctrlD.aluControl = corePkg::aluSub;  // Compare via zero flag
            end
            rvIsaPkg::opJal: begin
                ctrl.immSrcD    = rvIsaPkg::immJ;
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSrc = corePkg::resPcPlus4;
                ctrlD.jump      = 1'b1;
            end
            rvIsaPkg::opJalr: begin
                if (funct3 == rvIsaPkg::f3Jalr) begin
                    ctrlD.regWrite  = 1'b1;
                    ctrlD.resultSrc = corePkg::resPcPlus4;
                    ctrlD.jump      = 1'b1;
                    ctrlD.jalr      = 1'b1;
                    ctrlD.aluSrc    = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // ========================================
    // Pipeline of control
    always_ff @(posedge clk) begin
        if (!rstN || haz.flushE || haz.flushD) begin
            ctrlE <= '0;
        end else if (!haz.stallD) begin
            ctrlE <= ctrlD;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWriteM  <= 1'b0;
            memWriteM  <= 1'b0;
            resultSrcM <= corePkg::resAlu;
            regWriteW  <= 1'b0;
            resultSrcW <= corePkg::resAlu;
        end else begin
            regWriteM  <= ctrlE.regWrite;
            memWriteM  <= ctrlE.memWrite;
            resultSrcM <= ctrlE.resultSrc;
            regWriteW  <= regWriteM;
            resultSrcW <= resultSrcM;
        end
    end

    assign pcSrcE = (ctrlE.branch & ctrl.zeroE) | ctrlE.jump;

    assign ctrl.aluControlE = ctrlE.aluControl;
    assign ctrl.aluSrcE     = ctrlE.aluSrc;
    assign ctrl.jalrE       = ctrlE.jalr;
    assign ctrl.pcSrcE      = pcSrcE;
    assign ctrl.memWriteM   = memWriteM;
    assign ctrl.resultSrcW  = resultSrcW;
    assign ctrl.regWriteW   = regWriteW;

    assign haz.resultSrcE0 = (ctrlE.resultSrc == corePkg::resMem);
    assign haz.pcSrcE      = pcSrcE;
    assign haz.regWriteM   = regWriteM;
    assign haz.regWriteW   = regWriteW;

endmodule

//--- hw/datapath.sv
/* Five-stage datapath: PC, pipeline registers, immediate extension,
   operand forwarding and writeback result selection */
`timescale 1ns/1ps

module datapath #(
    parameter logic [corePkg::xlen-1:0] resetPc = '0
) (
    input  logic                     clk,
    input  logic                     rstN,
    ctrlIf.datapath                  ctrl,
    hazardIf.datapath                haz,
    output logic [corePkg::xlen-1:0] imemAddr,
    input  logic [corePkg::xlen-1:0] imemData,
    output logic [corePkg::xlen-1:0] dmemAddr,
    output logic [corePkg::xlen-1:0] dmemWData,
    input  logic [corePkg::xlen-1:0] dmemRData
);

    localparam int W = corePkg::xlen;

    logic [W-1:0] pcF, pcPlus4F, pcNextF, targetE;
    logic [W-1:0] instrD, pcD, pcPlus4D, immExtD, rd1D, rd2D;
    logic [W-1:0] pcE, pcPlus4E, immExtE, rd1E, rd2E, pcTargetE;
    logic [W-1:0] srcAE, srcBE, writeDataE, aluResultE;
    logic [W-1:0] aluResultM, writeDataM, pcPlus4M;
    logic [W-1:0] aluResultW, readDataW, pcPlus4W, resultW;
    logic [4:0]   rdD, rdE, rdM, rdW, rs1E, rs2E;

    function automatic logic [W-1:0] fwdMux(input corePkg::fwdSelT sel,
                                            input logic [W-1:0] regVal,
                                            input logic [W-1:0] wbVal,
                                            input logic [W-1:0] memVal);
        case (sel)
            corePkg::fwdMem: return memVal;
            corePkg::fwdWb:  return wbVal;
            default:         return regVal;
        endcase
    endfunction

    // ========================================
    // Fetch
    assign pcPlus4F = pcF + 32'd4;
    assign targetE  = ctrl.jalrE ? {aluResultE[W-1:1], 1'b0} : pcTargetE;
    assign pcNextF  = ctrl.pcSrcE ? targetE : pcPlus4F;

    always_ff @(posedge clk) begin
        if (!rstN) pcF <= resetPc;
        else if (!haz.stallF) pcF <= pcNextF;
    end
    assign imemAddr = pcF;

    always_ff @(posedge clk) begin
        if (!rstN || haz.flushD) instrD <= '0;  // Zero word decodes as bubble
        else if (!haz.stallD) instrD <= imemData;
    end

    always_ff @(posedge clk) begin
        if (!haz.stallD) begin
            pcD      <= pcF;
            pcPlus4D <= pcPlus4F;
        end
    end

    // ========================================
    // Decode
    assign ctrl.instrD = instrD;
    assign haz.rs1D    = instrD[19:15];
    assign haz.rs2D    = instrD[24:20];
    assign rdD         = instrD[11:7];

    always_comb begin
        case (ctrl.immSrcD)
            rvIsaPkg::immS: immExtD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            rvIsaPkg::immB: immExtD = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                                       instrD[11:8], 1'b0};
            rvIsaPkg::immJ: immExtD = {{12{instrD[31]}}, instrD[19:12], instrD[20],
                                       instrD[30:21], 1'b0};
            default:        immExtD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    regFile rf (
        .clk       (clk),
        .readAddr1 (instrD[19:15]),
        .readAddr2 (instrD[24:20]),
        .readData1 (rd1D),
        .readData2 (rd2D),
        .writeEn   (ctrl.regWriteW),
        .writeAddr (rdW),
        .writeData (resultW)
    );

    always_ff @(posedge clk) begin
        if (!rstN || haz.flushE) begin
            rs1E <= '0;
            rs2E <= '0;
            rdE  <= '0;
        end else begin
            rs1E <= instrD[19:15];
            rs2E <= instrD[24:20];
            rdE  <= rdD;
        end
    end

    always_ff @(posedge clk) begin
        rd1E     <= rd1D;
        rd2E     <= rd2D;
        pcE      <= pcD;
        pcPlus4E <= pcPlus4D;
        immExtE  <= immExtD;
    end

    // ========================================
    // Execute
    assign srcAE      = fwdMux(haz.forwardAE, rd1E, resultW, aluResultM);
    assign writeDataE = fwdMux(haz.forwardBE, rd2E, resultW, aluResultM);
    assign srcBE      = ctrl.aluSrcE ? immExtE : writeDataE;
    assign pcTargetE  = pcE + immExtE;

    alu alu (
        .srcA   (srcAE),
        .srcB   (srcBE),
        .aluOp  (ctrl.aluControlE),
        .result (aluResultE),
        .zero   (ctrl.zeroE)
    );

    assign haz.rs1E = rs1E;
    assign haz.rs2E = rs2E;
    assign haz.rdE  = rdE;

    // ========================================
    // Memory and Writeback
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdM <= '0;
            rdW <= '0;
        end else begin
            rdM <= rdE;
            rdW <= rdM;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        pcPlus4M   <= pcPlus4E;
        aluResultW <= aluResultM;
        readDataW  <= dmemRData;
        pcPlus4W   <= pcPlus4M;
    end

    assign dmemAddr  = aluResultM;
    assign dmemWData = writeDataM;
    assign haz.rdM   = rdM;
    assign haz.rdW   = rdW;

    always_comb begin
        case (ctrl.resultSrcW)
            corePkg::resMem:     resultW = readDataW;
            corePkg::resPcPlus4: resultW = pcPlus4W;  // Link value
            default:             resultW = aluResultW;
        endcase
    end

endmodule

//--- hw/hazardUnit.sv
/* Forwarding selection, load-use stall and flush on a taken control transfer */
`timescale 1ns/1ps

module hazardUnit (
    hazardIf.hazard haz
);

    logic lwStall;

    // Memory stage wins over Writeback
    function automatic corePkg::fwdSelT pickFwd(input logic [4:0] rs,
                                                input logic [4:0] rdM,
                                                input logic       regWriteM,
                                                input logic [4:0] rdW,
                                                input logic       regWriteW);
        if (rs == 5'd0) return corePkg::fwdNone;
        if (regWriteM && rs == rdM) return corePkg::fwdMem;
        if (regWriteW && rs == rdW) return corePkg::fwdWb;
        return corePkg::fwdNone;
    endfunction

    assign haz.forwardAE = pickFwd(haz.rs1E, haz.rdM, haz.regWriteM, haz.rdW, haz.regWriteW);
    assign haz.forwardBE = pickFwd(haz.rs2E, haz.rdM, haz.regWriteM, haz.rdW, haz.regWriteW);

    assign lwStall = haz.resultSrcE0 && haz.rdE != 5'd0 &&
                     (haz.rs1D == haz.rdE || haz.rs2D == haz.rdE);

    assign haz.stallF = lwStall;
    assign haz.stallD = lwStall;
    assign haz.flushD = haz.pcSrcE;
    assign haz.flushE = lwStall | haz.pcSrcE;  // Bubble or wrong path

endmodule

//--- hw/riscvCore.sv
/* Top of the pipelined RV32I core. Instruction and data memories
   sit outside and connect through plain ports */
`timescale 1ns/1ps

module riscvCore #(
    parameter logic [corePkg::xlen-1:0] resetPc = '0
) (
    input  logic                     clk,
    input  logic                     rstN,
    output logic [corePkg::xlen-1:0] imemAddr,
    input  logic [corePkg::xlen-1:0] imemData,
    output logic [corePkg::xlen-1:0] dmemAddr,
    output logic [corePkg::xlen-1:0] dmemWData,
    output logic                     dmemWe,
    input  logic [corePkg::xlen-1:0] dmemRData
);

    ctrlIf   ctrlBus ();
    hazardIf hazBus ();

    controller ctrlUnit (
        .clk  (clk),
        .rstN (rstN),
        .ctrl (ctrlBus.controller),
        .haz  (hazBus.controller)
    );

    datapath #(
        .resetPc (resetPc)
    ) dpath (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (ctrlBus.datapath),
        .haz       (hazBus.datapath),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .dmemAddr  (dmemAddr),
        .dmemWData (dmemWData),
        .dmemRData (dmemRData)
    );

    hazardUnit hazUnit (
        .haz (hazBus.hazard)
    );

    assign dmemWe = ctrlBus.memWriteM;

endmodule

//--- tests/coreTb.sv
/* Testbench for the pipelined core. Holds both memories, assembles small
   programs and checks the stores that each program makes */
`timescale 1ns/1ps

module coreTb;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } storeT;

    localparam logic [31:0] nop = 32'h00000013;  // addi x0, x0, 0

    logic        clk;
    logic        rstN;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWData;
    logic [31:0] dmemRData;
    logic        dmemWe;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] prog [$];
    storeT       seen [$];
    storeT       expStores [$];
    logic [31:0] seed = 32'h6daf5321;
    int          errors = 0;
    int          checks = 0;

    riscvCore #(
        .resetPc (32'h0)
    ) dut_i (
        .clk       (clk),
        .rstN      (rstN),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .dmemAddr  (dmemAddr),
        .dmemWData (dmemWData),
        .dmemWe    (dmemWe),
        .dmemRData (dmemRData)
    );

    assign imemData  = imem[imemAddr[9:2]];
    assign dmemRData = dmem[dmemAddr[9:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Data memory and store monitor; reset restores the fill
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= 32'hd0da0000 + i;
            end
            seen.delete();
        end else if (dmemWe) begin
            dmem[dmemAddr[9:2]] <= dmemWData;
            seen.push_back({dmemAddr, dmemWData});
        end
    end

    // ========================================
    // Instruction encoding
    function automatic logic [31:0] rType(input logic [2:0] f3, input logic [6:0] f7,
                                          input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rvIsaPkg::opReg};
    endfunction

    function automatic logic [31:0] iType(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input rvIsaPkg::opcodeT op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] sType(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], rvIsaPkg::f3Sw, imm[4:0], rvIsaPkg::opStore};
    endfunction

    function automatic logic [31:0] bType(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], rvIsaPkg::f3Beq, off[4:1], off[11],
                rvIsaPkg::opBranch};
    endfunction

    function automatic logic [31:0] jType(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rvIsaPkg::opJal};
    endfunction

    function automatic int curPc();
        return prog.size() * 4;
    endfunction

    task automatic addi(input int rd, input int rs1, input int imm);
        prog.push_back(iType(imm, rs1, rvIsaPkg::f3AddSub, rd, rvIsaPkg::opImm));
    endtask

    task automatic regOp(input logic [2:0] f3, input logic [6:0] f7,
                         input int rd, input int rs1, input int rs2);
        prog.push_back(rType(f3, f7, rd, rs1, rs2));
    endtask

    task automatic lw(input int rd, input int rs1, input int imm);
        prog.push_back(iType(imm, rs1, rvIsaPkg::f3Lw, rd, rvIsaPkg::opLoad));
    endtask

    task automatic sw(input int rs2, input int rs1, input int imm);
        prog.push_back(sType(rs2, rs1, imm));
    endtask

    task automatic beq(input int rs1, input int rs2, input int off);
        prog.push_back(bType(rs1, rs2, off));
    endtask

    task automatic jal(input int rd, input int off);
        prog.push_back(jType(rd, off));
    endtask

    task automatic jalr(input int rd, input int rs1, input int imm);
        prog.push_back(iType(imm, rs1, rvIsaPkg::f3Jalr, rd, rvIsaPkg::opJalr));
    endtask

    // ========================================
    // Reference values and checking
    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int randImm();
        logic [31:0] r;
        r = nextRand();
        return {{20{r[27]}}, r[27:16]};  // 12-bit signed
    endfunction

    function automatic logic [31:0] sltRef(input logic [31:0] x, input logic [31:0] y);
        return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    endfunction

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expStores.push_back({addr, data});
    endtask

    task automatic check(input string test, input string what,
                         input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t: %s %s is %h, expected %h", $time, test, what, got, exp);
        end
    endtask

    task automatic newProgram();
        prog.delete();
        expStores.delete();
    endtask

    // Program loads while the core is held in reset
    task automatic applyReset();
        @(posedge clk);
        #1;
        rstN = 1'b0;
        for (int i = 0; i < 256; i++) begin
            if (i < prog.size()) begin
                imem[i] = prog[i];
            end else begin
                imem[i] = nop;
            end
        end
        repeat (5) begin
            @(posedge clk);
            #1;
            check("reset", "dmemWe", {31'd0, dmemWe}, 32'd0);
            check("reset", "imemAddr", imemAddr, 32'd0);
        end
        rstN = 1'b1;
        #1;
        check("reset", "imemAddr after release", imemAddr, 32'd0);
        check("reset", "dmemWe after release", {31'd0, dmemWe}, 32'd0);
    endtask

    task automatic runProgram(input string name);
        int cycles;
        applyReset();
        cycles = 0;
        while (seen.size() < expStores.size() && cycles < 500) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (seen.size() >= expStores.size()) else begin
            errors++;
            $display("%s: program did not finish, %0d of %0d stores after 500 cycles",
                     name, seen.size(), expStores.size());
        end
        repeat (8) @(posedge clk);  // Let any stray store show up
        #1;
        check(name, "store count", seen.size(), expStores.size());
        for (int i = 0; i < expStores.size() && i < seen.size(); i++) begin
            check(name, $sformatf("store %0d address", i), seen[i].addr, expStores[i].addr);
            check(name, $sformatf("store %0d data", i), seen[i].data, expStores[i].data);
        end
    endtask

    // ========================================
    // Tests
    task automatic resetTest();
        newProgram();
        jal(0, 0);
        runProgram("reset");
    endtask

    task automatic arithTest();
        logic [31:0] a, b, c, x3, x4, x5, x6;
        a = randImm();
        b = randImm();
        c = randImm();
        x3 = a + b;
        x4 = x3 - a;
        x5 = x4 & b;
        x6 = x5 | x3;
        newProgram();
        addi(1, 0, a);
        addi(2, 0, b);
        regOp(rvIsaPkg::f3AddSub, rvIsaPkg::f7Base, 3, 1, 2);  // x2 from Memory, x1 from Wb
        regOp(rvIsaPkg::f3AddSub, rvIsaPkg::f7Sub, 4, 3, 1);
        regOp(rvIsaPkg::f3And, rvIsaPkg::f7Base, 5, 4, 2);
        regOp(rvIsaPkg::f3Or, rvIsaPkg::f7Base, 6, 5, 3);
        regOp(rvIsaPkg::f3Slt, rvIsaPkg::f7Base, 7, 1, 2);
        regOp(rvIsaPkg::f3Slt, rvIsaPkg::f7Base, 8, 2, 1);
        addi(9, 6, c);
        for (int r = 3; r <= 9; r++) begin
            sw(r, 0, (r - 3) * 4);
        end
        jal(0, 0);
        expectStore(32'd0, x3);
        expectStore(32'd4, x4);
        expectStore(32'd8, x5);
        expectStore(32'd12, x6);
        expectStore(32'd16, sltRef(a, b));
        expectStore(32'd20, sltRef(b, a));
        expectStore(32'd24, x6 + c);
        runProgram("arith");
    endtask

    task automatic loadUseTest();
        logic [31:0] v, k;
        v = randImm();
        k = randImm();
        newProgram();
        addi(1, 0, v);
        addi(2, 0, k);
        addi(10, 0, 64);
        sw(1, 10, 0);
        lw(3, 10, 0);
        regOp(rvIsaPkg::f3AddSub, rvIsaPkg::f7Base, 4, 3, 2);  // Stalls one cycle
        sw(4, 10, 4);
        jal(0, 0);
        expectStore(32'd64, v);
        expectStore(32'd68, v + k);
        runProgram("load-use");
    endtask

    task automatic branchTest();
        newProgram();
        addi(1, 0, 5);
        addi(2, 0, 5);
        addi(3, 0, 7);
        addi(10, 0, 128);
        beq(1, 2, 12);  // Taken over two stores
        sw(1, 10, 0);
        sw(2, 10, 4);
        sw(3, 10, 8);
        beq(1, 3, 8);   // Not taken
        sw(1, 10, 12);
        sw(2, 10, 16);
        jal(0, 0);
        expectStore(32'd136, 32'd7);
        expectStore(32'd140, 32'd5);
        expectStore(32'd144, 32'd5);
        runProgram("branch");
    endtask

    task automatic jumpTest();
        int jalPc, jalrPc, target;
        newProgram();
        addi(10, 0, 192);
        jalPc = curPc();
        jal(1, 12);
        sw(0, 10, 0);
        sw(0, 10, 4);
        sw(1, 10, 8);
        target = curPc() + 20;  // Past jalr and three skipped stores
        addi(5, 0, target);
        jalrPc = curPc();
        jalr(2, 5, 0);
        sw(0, 10, 12);
        sw(0, 10, 16);
        sw(0, 10, 20);
        sw(2, 10, 24);
        sw(5, 10, 28);
        jal(0, 0);
        expectStore(32'd200, jalPc + 4);
        expectStore(32'd216, jalrPc + 4);
        expectStore(32'd220, target);
        runProgram("jump");
    endtask

    initial begin
        rstN = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = nop;
        end
        resetTest();
        arithTest();
        arithTest();
        loadUseTest();
        branchTest();
        jumpTest();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/rvIsaPkg.sv
hw/corePkg.sv
hw/coreIfs.sv
hw/regFile.sv
hw/alu.sv
hw/controller.sv
hw/datapath.sv
hw/hazardUnit.sv
hw/riscvCore.sv
tests/coreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module coreTb -f verilog.f -Mdir obj_dir

./obj_dir/VcoreTb | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation clean"
